// ==== src/tigerPkg.sv ====
package tigerPkg;

	localparam int regNumWidth = 5;
	localparam int controlWidth = 31;

	// control word layout, lsb positions
	localparam int ctlDestRegLsb = 0;   // 5 bits
	localparam int ctlBranchLsb = 5;    // 3 bits
	localparam int ctlAluOpLsb = 8;     // 5 bits
	localparam int ctlFlagsLsb = 13;    // 16 bits
	localparam int ctlDCacheFlush = 29;
	localparam int ctlICacheFlush = 30;

	// bit numbers inside the 16 flag bits, 13..15 reserved
	localparam int flagRegWrite = 0;
	localparam int flagMemRead = 1;
	localparam int flagMemWrite = 2;
	localparam int flagMemByte = 3;
	localparam int flagMemHalf = 4;
	localparam int flagMemSigned = 5;
	localparam int flagAluSrcImm = 6;
	localparam int flagImmZeroExt = 7;
	localparam int flagLink = 8;
	localparam int flagJumpReg = 9;
	localparam int flagCopRead = 10;
	localparam int flagCopWrite = 11;
	localparam int flagShiftImm = 12;

	typedef enum logic [4:0] {
		aluAdd, aluAddu, aluSub, aluSubu, aluAnd, aluOr, aluXor, aluNor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui, aluPassB
	} aluOp_t;

	typedef enum logic [2:0] {
		brNone, brBeq, brBne, brBlez, brBgtz, brBltz, brBgez, brJump
	} branchType_t;

	// primary opcodes
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opRegImm = 6'h01;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opJal = 6'h03;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opBlez = 6'h06;
	localparam logic [5:0] opBgtz = 6'h07;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opSlti = 6'h0a;
	localparam logic [5:0] opAndi = 6'h0c;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opCop0 = 6'h10;
	localparam logic [5:0] opLb = 6'h20;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSb = 6'h28;
	localparam logic [5:0] opSw = 6'h2b;

	// special function codes
	localparam logic [5:0] fnSll = 6'h00;
	localparam logic [5:0] fnSrl = 6'h02;
	localparam logic [5:0] fnSra = 6'h03;
	localparam logic [5:0] fnJr = 6'h08;
	localparam logic [5:0] fnJalr = 6'h09;
	localparam logic [5:0] fnSyscall = 6'h0c;
	localparam logic [5:0] fnBreak = 6'h0d;
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnNor = 6'h27;
	localparam logic [5:0] fnSlt = 6'h2a;
	localparam logic [5:0] fnSltu = 6'h2b;

	// cop0 rs field: move from / move to
	localparam logic [4:0] copMf = 5'd0;
	localparam logic [4:0] copMt = 5'd4;

	// cop0 register numbers
	localparam logic [4:0] copCause = 5'd0;
	localparam logic [4:0] copStatus = 5'd1;
	localparam logic [4:0] copEpc = 5'd2;
	localparam logic [4:0] copCacheCtl = 5'd3;

	localparam logic [3:0] causeSyscall = 4'd8;
	localparam logic [3:0] causeBreak = 4'd9;
	localparam logic [3:0] causeOther = 4'd15;

	localparam logic [31:0] resetPc = 32'h0000_0000;
	localparam logic [31:0] excVector = 32'h0000_0080;
	localparam logic [31:0] resetSp = 32'h0078_0000;   // initial $sp

endpackage

// ==== src/tigerDecoder.sv ====
`timescale 1ns/10ps

module tigerDecoder import tigerPkg::*; (
	input  logic [31:0]            instr,
	output logic [15:0]            controls,
	output aluOp_t                 aluOp,
	output branchType_t            branchType,
	output logic [regNumWidth-1:0] destReg
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rsField;
	logic [4:0] rtField;
	logic [4:0] rdField;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rsField = instr[25:21];   // also cop0 sub-op
	assign rtField = instr[20:16];
	assign rdField = instr[15:11];

	always_comb begin
		controls = '0;   // unknown opcode -> all zero
		aluOp = aluAdd;
		branchType = brNone;
		destReg = '0;
		case (opcode)
			opSpecial: begin
				case (funct)
					fnSll, fnSrl, fnSra: begin
						controls[flagRegWrite] = 1'b1;
						controls[flagShiftImm] = 1'b1;   // shamt field
						aluOp = (funct == fnSll) ? aluSll : (funct == fnSrl) ? aluSrl : aluSra;
						destReg = rdField;
					end
					fnJr: begin
						controls[flagJumpReg] = 1'b1;
						branchType = brJump;
					end
					fnJalr: begin
						controls[flagJumpReg] = 1'b1;
						controls[flagLink] = 1'b1;
						controls[flagRegWrite] = 1'b1;
						branchType = brJump;
						destReg = rdField;
					end
					fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu: begin
						controls[flagRegWrite] = 1'b1;
						destReg = rdField;
						case (funct)
							fnAdd: aluOp = aluAdd;
							fnAddu: aluOp = aluAddu;
							fnSub: aluOp = aluSub;
							fnSubu: aluOp = aluSubu;
							fnAnd: aluOp = aluAnd;
							fnOr: aluOp = aluOr;
							fnXor: aluOp = aluXor;
							fnNor: aluOp = aluNor;
							fnSlt: aluOp = aluSlt;
							default: aluOp = aluSltu;
						endcase
					end
					default: ;   // syscall/break handled in decode stage
				endcase
			end
			opRegImm: branchType = rtField[0] ? brBgez : brBltz;
			opJ: branchType = brJump;
			opJal: begin
				branchType = brJump;
				controls[flagLink] = 1'b1;
				controls[flagRegWrite] = 1'b1;
				destReg = 5'd31;   // $ra
			end
			opBeq: branchType = brBeq;
			opBne: branchType = brBne;
			opBlez: branchType = brBlez;
			opBgtz: branchType = brBgtz;
			opAddiu, opSlti, opAndi, opOri, opLui: begin
				controls[flagRegWrite] = 1'b1;
				controls[flagAluSrcImm] = 1'b1;
				controls[flagImmZeroExt] = (opcode == opAndi) || (opcode == opOri);
				destReg = rtField;
				case (opcode)
					opAddiu: aluOp = aluAddu;
					opSlti: aluOp = aluSlt;
					opAndi: aluOp = aluAnd;
					opOri: aluOp = aluOr;
					default: aluOp = aluLui;
				endcase
			end
			opCop0: begin
				aluOp = aluPassB;
				if (rsField == copMf) begin
					controls[flagCopRead] = 1'b1;   // mfc0 rt <- cop[rd]
					controls[flagRegWrite] = 1'b1;
					destReg = rtField;
				end else if (rsField == copMt) begin
					controls[flagCopWrite] = 1'b1;   // mtc0 cop[rd] <- rt
					destReg = rdField;
				end
			end
			opLw, opLb: begin
				controls[flagMemRead] = 1'b1;
				controls[flagRegWrite] = 1'b1;
				controls[flagAluSrcImm] = 1'b1;
				controls[flagMemByte] = (opcode == opLb);
				controls[flagMemSigned] = (opcode == opLb);   // lb sign extends
				destReg = rtField;
			end
			opSw, opSb: begin
				controls[flagMemWrite] = 1'b1;
				controls[flagAluSrcImm] = 1'b1;
				controls[flagMemByte] = (opcode == opSb);
			end
			default: ;
		endcase
	end

endmodule

// ==== src/tigerBranch.sv ====
`timescale 1ns/10ps

module tigerBranch import tigerPkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    freeze,      // stall or clear
	input  logic                    exception,
	input  logic [31:0]             instr,
	input  logic [controlWidth-1:0] control,
	input  logic [31:0]             rs,          // bypassed operands
	input  logic [31:0]             rt,
	output logic [31:0]             branchOut,   // registered link address
	output logic [31:0]             epc,
	output logic                    branchDelay,
	output logic [31:0]             nextPc
);

	logic [31:0] pc;
	logic [31:0] pcPlus4;
	logic [31:0] pcPlus8;
	logic [31:0] branchOffset;
	logic [31:0] target;
	logic        taken;
	logic        jumpReg;
	logic        link;
	branchType_t brType;

	assign brType = branchType_t'(control[ctlBranchLsb +: 3]);
	assign jumpReg = control[ctlFlagsLsb + flagJumpReg];
	assign link = control[ctlFlagsLsb + flagLink];

	assign pcPlus4 = pc + 32'd4;
	assign pcPlus8 = pc + 32'd8;
	assign branchOffset = {{14{instr[15]}}, instr[15:0], 2'b00};

	// condition on bypassed rs/rt
	always_comb begin
		case (brType)
			brBeq: taken = (rs == rt);
			brBne: taken = (rs != rt);
			brBlez: taken = rs[31] || (rs == '0);
			brBgtz: taken = !rs[31] && (rs != '0);
			brBltz: taken = rs[31];
			brBgez: taken = !rs[31];
			brJump: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (jumpReg)
			target = rs;   // jr / jalr
		else if (brType == brJump)
			target = {pcPlus4[31:28], instr[25:0], 2'b00};
		else
			target = pcPlus4 + branchOffset;
	end

	assign nextPc = exception ? excVector : taken ? target : pcPlus4;

	// return address, back up onto the branch when in a delay slot
	assign epc = branchDelay ? pc - 32'd4 : pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetPc;
			branchDelay <= 1'b0;
			branchOut <= '0;
		end else if (!freeze) begin
			pc <= nextPc;
			// vector fetch is never a delay slot
			branchDelay <= !exception && (brType != brNone);
			branchOut <= (link && !exception) ? pcPlus8 : '0;
		end
	end

endmodule

// ==== src/tigerDecode.sv ====
`timescale 1ns/10ps

module tigerDecode import tigerPkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    stall,
	input  logic                    clear,
	input  logic                    irq,
	input  logic [5:0]              irqNumber,
	input  logic [31:0]             instr,
	input  logic                    writeRegEn,      // write-back strobe, gpr
	input  logic                    writeRegEnCop,   // write-back strobe, cop0
	input  logic [regNumWidth-1:0]  writeRegNum,
	input  logic [31:0]             writeRegData,
	output logic                    exception,
	output logic [controlWidth-1:0] controlDe,
	output logic [31:0]             instrEx,
	output logic [controlWidth-1:0] controlEx,
	output logic [31:0]             rsEx,
	output logic [31:0]             rtEx,
	output logic [31:0]             copOutEx,
	output logic [31:0]             branchOutEx,
	output logic [31:0]             nextPc
);

	logic [15:0]            controls;
	aluOp_t                 aluOp;
	branchType_t            branchType;
	logic [regNumWidth-1:0] destReg;
	logic [controlWidth-1:0] control;
	logic                   iCacheFlush;
	logic                   dCacheFlush;

	logic [31:0]            regFile [31:1];   // $0 not stored
	logic [regNumWidth-1:0] rsNum;
	logic [regNumWidth-1:0] rtNum;
	logic [regNumWidth-1:0] rdNum;
	logic [31:0]            rsVal;
	logic [31:0]            rtVal;

	logic [31:0] cause;
	logic [31:0] status;
	logic [31:0] epc;
	logic [31:0] epcDe;
	logic [31:0] copRead;
	logic [31:0] linkAddr;
	logic        branchDelay;
	logic        syscallDe;
	logic        breakDe;
	logic        irqTaken;
	logic        excTaken;
	logic [3:0]  excCode;

	tigerDecoder decoder (
		.instr(instr),
		.controls(controls),
		.aluOp(aluOp),
		.branchType(branchType),
		.destReg(destReg)
	);

	// flush requests come straight off the write-back bus
	assign iCacheFlush = writeRegEnCop && (writeRegNum == copCacheCtl) && writeRegData[0];
	assign dCacheFlush = writeRegEnCop && (writeRegNum == copCacheCtl) && writeRegData[1];

	assign control = {iCacheFlush, dCacheFlush, controls, aluOp, branchType, destReg};
	assign controlDe = control;

	assign rsNum = instr[25:21];
	assign rtNum = instr[20:16];
	assign rdNum = instr[15:11];

	// $0 reads zero, then forward a same-cycle write-back
	assign rsVal = (rsNum == '0) ? '0
		: (writeRegEn && writeRegNum == rsNum) ? writeRegData
		: regFile[rsNum];
	assign rtVal = (rtNum == '0) ? '0
		: (writeRegEn && writeRegNum == rtNum) ? writeRegData
		: regFile[rtNum];

	always_ff @(posedge clk) begin
		if (reset)
			regFile[29] <= resetSp;
		else if (writeRegEn && writeRegNum != '0)
			regFile[writeRegNum] <= writeRegData;   // writes ignore stall
	end

	assign syscallDe = (instr[31:26] == opSpecial) && (instr[5:0] == fnSyscall);
	assign breakDe = (instr[31:26] == opSpecial) && (instr[5:0] == fnBreak);
	assign irqTaken = irq && !status[0];   // status bit 0 masks irq
	assign exception = irqTaken || syscallDe || breakDe;
	assign excTaken = exception && !stall && !clear;

	assign excCode = breakDe ? causeBreak : syscallDe ? causeSyscall : causeOther;

	always_ff @(posedge clk) begin
		if (reset) begin
			cause <= '0;
			status <= '0;
			epc <= '0;
		end else begin
			if (writeRegEnCop && writeRegNum == copStatus)
				status <= writeRegData;
			if (excTaken) begin
				if (irqTaken)
					cause <= {branchDelay, 15'd0, irqNumber, 10'd0};
				else
					cause <= {branchDelay, 25'd0, excCode, 2'b00};
				status[0] <= 1'b1;   // mask further irqs
				epc <= epcDe;
			end
		end
	end

	// cop0 read port, rd selects
	always_comb begin
		case (rdNum)
			copCause: copRead = cause;
			copStatus: copRead = status;
			copEpc: copRead = epc;
			default: copRead = '0;
		endcase
	end

	// Ex pipeline register
	always_ff @(posedge clk) begin
		if (reset || (!stall && (clear || exception))) begin
			instrEx <= '0;
			controlEx <= '0;
			rsEx <= '0;
			rtEx <= '0;
			copOutEx <= '0;
		end else if (!stall) begin
			instrEx <= instr;
			controlEx <= control;
			rsEx <= rsVal;
			rtEx <= rtVal;
			copOutEx <= copRead;
		end
	end

	// link address only valid alongside a linking controlEx, zero after clear
	assign branchOutEx = controlEx[ctlFlagsLsb + flagLink] ? linkAddr : '0;

	tigerBranch branch (
		.clk(clk),
		.reset(reset),
		.freeze(stall || clear),
		.exception(exception),
		.instr(instr),
		.control(control),
		.rs(rsVal),
		.rt(rtVal),
		.branchOut(linkAddr),
		.epc(epcDe),
		.branchDelay(branchDelay),
		.nextPc(nextPc)
	);

endmodule

// ==== src/tigerFrontEnd.sv ====
`timescale 1ns/10ps

module tigerFrontEnd import tigerPkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    stall,
	input  logic                    clear,
	input  logic                    irq,
	input  logic [5:0]              irqNumber,
	input  logic [31:0]             instr,
	input  logic                    writeRegEn,
	input  logic                    writeRegEnCop,
	input  logic [regNumWidth-1:0]  writeRegNum,
	input  logic [31:0]             writeRegData,
	output logic                    exception,
	output logic [controlWidth-1:0] controlDe,
	output logic [31:0]             instrEx,
	output logic [controlWidth-1:0] controlEx,
	output logic [31:0]             rsEx,
	output logic [31:0]             rtEx,
	output logic [31:0]             copOutEx,
	output logic [31:0]             branchOutEx,
	output logic [31:0]             nextPc
);

	// subsystem boundary, fetch and later stages sit outside
	tigerDecode decode (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.clear(clear),
		.irq(irq),
		.irqNumber(irqNumber),
		.instr(instr),
		.writeRegEn(writeRegEn),
		.writeRegEnCop(writeRegEnCop),
		.writeRegNum(writeRegNum),
		.writeRegData(writeRegData),
		.exception(exception),
		.controlDe(controlDe),
		.instrEx(instrEx),
		.controlEx(controlEx),
		.rsEx(rsEx),
		.rtEx(rtEx),
		.copOutEx(copOutEx),
		.branchOutEx(branchOutEx),
		.nextPc(nextPc)
	);

endmodule

// ==== tb/tigerVectors.svh ====
// each row: instr, expected flags, aluOp, branchType, destReg, expected exception
// wb() adds a write-back (gpr strobe, cop strobe, number, data, random data)
// ctl() adds stall, clear, irq and irq number to the last row
task automatic loadVectors();
	int r;
	row(rType(29, 0, 3, fnAddu), fRw, aluAddu, brNone, 5'd3, 1'b0);   // $sp after reset
	for (r = 1; r < 32; r++) begin
		if (r != 29) begin
			row(nopInstr, fRw | fSh, aluSll, brNone, 5'd0, 1'b0);
			wb(1'b1, 1'b0, 5'(r), 32'd0, 1'b1);
		end
	end
	row(rType(6, 7, 5, fnAddu), fRw, aluAddu, brNone, 5'd5, 1'b0);
	wb(1'b1, 1'b0, 5'd6, 32'd0, 1'b1);   // bypass on $6
	row(rType(1, 2, 8, fnAddu), fRw, aluAddu, brNone, 5'd8, 1'b0);
	row(rType(0, 4, 9, fnOr), fRw, aluOr, brNone, 5'd9, 1'b0);
	wb(1'b1, 1'b0, 5'd0, 32'hdead_beef, 1'b0);   // write to $0 is dropped, not forwarded
	row(iType(opLw, 1, 10, 16'd4), fMr | fRw | fImm, aluAdd, brNone, 5'd10, 1'b0);
	row(iType(opSw, 1, 2, 16'd8), fMw | fImm, aluAdd, brNone, 5'd0, 1'b0);
	row(iType(opLb, 3, 11, 16'd0), fMr | fRw | fImm | fMb | fMs, aluAdd, brNone, 5'd11, 1'b0);
	row(iType(opOri, 1, 12, 16'h55), fRw | fImm | fZe, aluOr, brNone, 5'd12, 1'b0);
	row(iType(opLui, 0, 13, 16'h1234), fRw | fImm, aluLui, brNone, 5'd13, 1'b0);
	row(iType(opSlti, 2, 14, 16'hffff), fRw | fImm, aluSlt, brNone, 5'd14, 1'b0);
	row(iType(opAndi, 3, 15, 16'hff), fRw | fImm | fZe, aluAnd, brNone, 5'd15, 1'b0);
	row(rType(4, 5, 16, fnSub), fRw, aluSub, brNone, 5'd16, 1'b0);
	row(rType(0, 5, 17, fnSll), fRw | fSh, aluSll, brNone, 5'd17, 1'b0);
	row(iType(opBeq, 1, 1, 16'd4), 16'd0, aluAdd, brBeq, 5'd0, 1'b0);   // taken
	row(rType(1, 2, 18, fnAddu), fRw, aluAddu, brNone, 5'd18, 1'b0);   // delay slot
	row(iType(opBne, 1, 1, 16'd8), 16'd0, aluAdd, brBne, 5'd0, 1'b0);   // not taken
	row(iType(opBlez, 2, 0, 16'd2), 16'd0, aluAdd, brBlez, 5'd0, 1'b0);
	row(iType(opBgtz, 2, 0, 16'd2), 16'd0, aluAdd, brBgtz, 5'd0, 1'b0);
	row(iType(opRegImm, 3, 0, 16'hfffc), 16'd0, aluAdd, brBltz, 5'd0, 1'b0);
	row(iType(opRegImm, 3, 1, 16'd6), 16'd0, aluAdd, brBgez, 5'd0, 1'b0);
	row(jType(opJ, 26'h40), 16'd0, aluAdd, brJump, 5'd0, 1'b0);
	row(nopInstr, fRw | fSh, aluSll, brNone, 5'd0, 1'b0);
	row(jType(opJal, 26'h80), fLink | fRw, aluAdd, brJump, 5'd31, 1'b0);
	row(nopInstr, fRw | fSh, aluSll, brNone, 5'd0, 1'b0);   // link address visible
	row(rType(31, 0, 0, fnJr), fJr, aluAdd, brJump, 5'd0, 1'b0);
	row(nopInstr, fRw | fSh, aluSll, brNone, 5'd0, 1'b0);
	row(iType(opBeq, 1, 1, 16'd2), 16'd0, aluAdd, brBeq, 5'd0, 1'b0);
	row(rType(0, 0, 0, fnSyscall), 16'd0, aluAdd, brNone, 5'd0, 1'b1);   // in delay slot
	row(copInstr(copMf, 8, copCause), fCr | fRw, aluPassB, brNone, 5'd8, 1'b0);
	row(copInstr(copMf, 8, copEpc), fCr | fRw, aluPassB, brNone, 5'd8, 1'b0);
	row(copInstr(copMf, 8, copStatus), fCr | fRw, aluPassB, brNone, 5'd8, 1'b0);
	row(nopInstr, fRw | fSh, aluSll, brNone, 5'd0, 1'b0);
	wb(1'b0, 1'b1, copStatus, 32'd0, 1'b0);   // unmask irq
	row(nopInstr, fRw | fSh, aluSll, brNone, 5'd0, 1'b1);
	ctl(1'b0, 1'b0, 1'b1, 6'h2a);
	row(copInstr(copMf, 9, copCause), fCr | fRw, aluPassB, brNone, 5'd9, 1'b0);
	row(nopInstr, fRw | fSh, aluSll, brNone, 5'd0, 1'b0);
	ctl(1'b0, 1'b0, 1'b1, 6'h15);   // masked, nothing taken
	row(rType(0, 0, 0, fnBreak), 16'd0, aluAdd, brNone, 5'd0, 1'b1);
	row(copInstr(copMf, 10, copCause), fCr | fRw, aluPassB, brNone, 5'd10, 1'b0);
	row(rType(1, 2, 19, fnAddu), fRw, aluAddu, brNone, 5'd19, 1'b0);
	row(rType(3, 4, 20, fnAddu), fRw, aluAddu, brNone, 5'd20, 1'b0);
	ctl(1'b1, 1'b0, 1'b0, 6'd0);   // stall
	row(rType(3, 4, 21, fnAddu), fRw, aluAddu, brNone, 5'd21, 1'b0);
	ctl(1'b0, 1'b1, 1'b0, 6'd0);   // clear
	row(copInstr(copMt, 2, copCacheCtl), fCw, aluPassB, brNone, 5'd3, 1'b0);
	wb(1'b0, 1'b1, copCacheCtl, 32'd3, 1'b0);   // flush both
	row(nopInstr, fRw | fSh, aluSll, brNone, 5'd0, 1'b0);
	wb(1'b0, 1'b1, copCacheCtl, 32'd1, 1'b0);   // icache only
	row(nopInstr, fRw | fSh, aluSll, brNone, 5'd0, 1'b0);
endtask

// ==== tb/tigerFrontEndTb.sv ====
`timescale 1ns/10ps

module tigerFrontEndTb import tigerPkg::*; ();

	typedef struct packed {
		logic [31:0] instr;
		logic        wbEn;
		logic        wbCop;
		logic [4:0]  wbNum;
		logic [31:0] wbData;
		logic        randData;   // replace wbData with $urandom
		logic        stall;
		logic        clear;
		logic        irq;
		logic [5:0]  irqNum;
		logic        expExc;
		logic [15:0] flags;
		logic [4:0]  alu;
		logic [2:0]  br;
		logic [4:0]  dest;
	} vector_t;

	localparam logic [15:0] fRw = 16'(1 << flagRegWrite);
	localparam logic [15:0] fMr = 16'(1 << flagMemRead);
	localparam logic [15:0] fMw = 16'(1 << flagMemWrite);
	localparam logic [15:0] fMb = 16'(1 << flagMemByte);
	localparam logic [15:0] fMs = 16'(1 << flagMemSigned);
	localparam logic [15:0] fImm = 16'(1 << flagAluSrcImm);
	localparam logic [15:0] fZe = 16'(1 << flagImmZeroExt);
	localparam logic [15:0] fLink = 16'(1 << flagLink);
	localparam logic [15:0] fJr = 16'(1 << flagJumpReg);
	localparam logic [15:0] fCr = 16'(1 << flagCopRead);
	localparam logic [15:0] fCw = 16'(1 << flagCopWrite);
	localparam logic [15:0] fSh = 16'(1 << flagShiftImm);
	localparam logic [31:0] nopInstr = 32'd0;   // sll $0,$0,0

	logic clk, reset, stall, clear, irq, writeRegEn, writeRegEnCop;
	logic [5:0] irqNumber;
	logic [31:0] instr, writeRegData;
	logic [regNumWidth-1:0] writeRegNum;
	logic exception;
	logic [controlWidth-1:0] controlDe, controlEx;
	logic [31:0] instrEx, rsEx, rtEx, copOutEx, branchOutEx, nextPc;

	vector_t rows[$];
	vector_t cur;
	int errors = 0;
	bit loaded = 0;

	// reference model state
	logic [31:0] regs [32];
	logic [31:0] pcM, causeM, statusM, epcM, dataNow;
	logic bdM;
	logic [31:0] instrExM, rsExM, rtExM, copExM, branchExM;
	logic [controlWidth-1:0] ctlExM;

	tigerFrontEnd dut (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] rType(int rs, int rt, int rd, logic [5:0] fn);
		return {opSpecial, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] iType(logic [5:0] op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] jType(logic [5:0] op, logic [25:0] index);
		return {op, index};
	endfunction

	function automatic logic [31:0] copInstr(logic [4:0] sub, int rt, logic [4:0] rd);
		return {opCop0, sub, 5'(rt), rd, 11'd0};
	endfunction

	task automatic row(logic [31:0] i, logic [15:0] fl, logic [4:0] alu, logic [2:0] br,
			logic [4:0] dest, logic expExc);
		vector_t v;
		v = '0;
		v.instr = i;
		v.flags = fl;
		v.alu = alu;
		v.br = br;
		v.dest = dest;
		v.expExc = expExc;
		rows.push_back(v);
	endtask

	task automatic wb(logic en, logic cop, logic [4:0] num, logic [31:0] data, logic rnd);
		vector_t v;
		v = rows.pop_back();
		v.wbEn = en;
		v.wbCop = cop;
		v.wbNum = num;
		v.wbData = data;
		v.randData = rnd;
		rows.push_back(v);
	endtask

	task automatic ctl(logic st, logic cl, logic ir, logic [5:0] num);
		vector_t v;
		v = rows.pop_back();
		v.stall = st;
		v.clear = cl;
		v.irq = ir;
		v.irqNum = num;
		rows.push_back(v);
	endtask

	`include "tigerVectors.svh"

	task automatic checkValue(logic [31:0] actual, logic [31:0] expected, string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			errors++;
		end
	endtask

	// control word built from the package field positions
	function automatic logic [controlWidth-1:0] packControl(vector_t v, logic iF, logic dF);
		logic [controlWidth-1:0] c;
		c = '0;
		c[ctlDestRegLsb +: 5] = v.dest;
		c[ctlBranchLsb +: 3] = v.br;
		c[ctlAluOpLsb +: 5] = v.alu;
		c[ctlFlagsLsb +: 16] = v.flags;
		c[ctlDCacheFlush] = dF;
		c[ctlICacheFlush] = iF;
		return c;
	endfunction

	function automatic logic [31:0] readReg(logic [4:0] n);
		if (n == 0)
			return 32'd0;
		if (cur.wbEn && cur.wbNum == n)
			return dataNow;   // forwarded write-back
		return regs[n];
	endfunction

	function automatic logic branchTaken(logic [2:0] br, logic [31:0] a, logic [31:0] b);
		case (br)
			brBeq: return a == b;
			brBne: return a != b;
			brBlez: return $signed(a) <= 0;
			brBgtz: return $signed(a) > 0;
			brBltz: return $signed(a) < 0;
			brBgez: return $signed(a) >= 0;
			brJump: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic applyRow(int i);
		cur = rows[i];
		dataNow = cur.randData ? $urandom : cur.wbData;
		instr = cur.instr;
		writeRegEn = cur.wbEn;
		writeRegEnCop = cur.wbCop;
		writeRegNum = cur.wbNum;
		writeRegData = dataNow;
		stall = cur.stall;
		clear = cur.clear;
		irq = cur.irq;
		irqNumber = cur.irqNum;
	endtask

	// combinational checks, then advance the model across the coming edge
	task automatic checkAndStep();
		logic [31:0] rsM, rtM, pc4, tgt, npc, copR;
		logic [controlWidth-1:0] ctlM;
		logic iF, dF, irqHit, freeze;
		rsM = readReg(cur.instr[25:21]);
		rtM = readReg(cur.instr[20:16]);
		iF = cur.wbCop && cur.wbNum == copCacheCtl && dataNow[0];
		dF = cur.wbCop && cur.wbNum == copCacheCtl && dataNow[1];
		ctlM = packControl(cur, iF, dF);
		pc4 = pcM + 32'd4;
		if (cur.flags[flagJumpReg])
			tgt = rsM;
		else if (cur.br == brJump)
			tgt = {pc4[31:28], cur.instr[25:0], 2'b00};
		else
			tgt = pc4 + {{14{cur.instr[15]}}, cur.instr[15:0], 2'b00};
		npc = cur.expExc ? excVector : branchTaken(cur.br, rsM, rtM) ? tgt : pc4;
		checkValue(32'(exception), 32'(cur.expExc), "exception");
		checkValue(32'(controlDe), 32'(ctlM), "controlDe");
		checkValue(nextPc, npc, "nextPc");
		case (cur.instr[15:11])
			copCause: copR = causeM;
			copStatus: copR = statusM;
			copEpc: copR = epcM;
			default: copR = 32'd0;
		endcase
		irqHit = cur.irq && !statusM[0];
		freeze = cur.stall || cur.clear;
		if (!cur.stall) begin
			if (cur.clear || cur.expExc) begin
				instrExM = 0;
				ctlExM = 0;
				rsExM = 0;
				rtExM = 0;
				copExM = 0;
				branchExM = 0;
			end else begin
				instrExM = cur.instr;
				ctlExM = ctlM;
				rsExM = rsM;
				rtExM = rtM;
				copExM = copR;
				branchExM = cur.flags[flagLink] ? pcM + 32'd8 : 32'd0;   // link address
			end
		end
		if (cur.wbCop && cur.wbNum == copStatus)
			statusM = dataNow;
		if (cur.expExc && !freeze) begin
			if (irqHit)
				causeM = {bdM, 15'd0, cur.irqNum, 10'd0};
			else
				causeM = {bdM, 25'd0, (cur.instr[5:0] == fnBreak) ? causeBreak : causeSyscall, 2'b00};
			statusM[0] = 1'b1;
			epcM = bdM ? pcM - 32'd4 : pcM;
		end
		if (cur.wbEn && cur.wbNum != 0)
			regs[cur.wbNum] = dataNow;
		if (!freeze) begin
			bdM = !cur.expExc && cur.br != brNone;
			pcM = npc;
		end
	endtask

	task automatic checkRegistered();
		checkValue(instrEx, instrExM, "instrEx");
		checkValue(32'(controlEx), 32'(ctlExM), "controlEx");
		checkValue(rsEx, rsExM, "rsEx");
		checkValue(rtEx, rtExM, "rtEx");
		checkValue(copOutEx, copExM, "copOutEx");
		checkValue(branchOutEx, branchExM, "branchOutEx");
	endtask

	initial begin
		wait (loaded);
		#((rows.size() + 40) * 8);
		$display("watchdog: simulation did not reach the end of the vector table in time");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		void'($urandom(57));
		clk = 0;
		reset = 1;
		{stall, clear, irq, writeRegEn, writeRegEnCop} = '0;
		irqNumber = 0;
		instr = 0;
		writeRegNum = 0;
		writeRegData = 0;
		for (int r = 0; r < 32; r++)
			regs[r] = 32'd0;
		regs[29] = resetSp;
		{pcM, causeM, statusM, epcM, bdM} = '0;
		{instrExM, rsExM, rtExM, copExM, branchExM, ctlExM} = '0;
		loadVectors();
		loaded = 1;
		repeat (16) @(posedge clk);
		#1 reset = 0;
		for (int i = 0; i < rows.size(); i++) begin
			applyRow(i);
			#4;
			checkAndStep();
			@(posedge clk);
			#1;
			checkRegistered();
		end
		$display("%0d errors over %0d vectors", errors, rows.size());
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+tb
src/tigerPkg.sv
src/tigerDecoder.sv
src/tigerBranch.sv
src/tigerDecode.sv
src/tigerFrontEnd.sv
tb/tigerFrontEndTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tigerFrontEndTb -f src.f -o simTiger
./obj_dir/simTiger > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	exit 1
fi
grep -q '\*\*\* PASSED \*\*\*' sim.log
